/* all.f */
+incdir+include
verilog/bus_pkg.sv
verilog/map_pkg.sv
verilog/sys_bus_if.sv
verilog/bus_controller.sv
verilog/word_ram.sv
verilog/io_regs.sv
verilog/bus_top.sv
bench/bus_checker.sv
bench/tb_bus.sv

/* bench/bus_checker.sv */
`timescale 1ns/1ps
`include "bus_cfg.svh"

module bus_checker
  import bus_pkg::*, map_pkg::*;
(
  input  logic      clock, reset_n,
  input  bus_addr_t cpu_address, vga_address,
  input  logic      cpu_read, cpu_write, vga_read, map,
  input  bus_be_t   cpu_be,
  input  bus_data_t cpu_writedata, cpu_readdata, vga_readdata,
  input  logic      cpu_wait, vga_wait,
  output int        pass_count, fail_count
);

  string     test_name = "none"; // set by tb_bus at each test
  int        passes    = 0;
  int        fails     = 0;
  bus_data_t ram_model [`BUS_RAM_WORDS];
  bus_data_t io_model  [`BUS_IO_REGS];

  assign pass_count = passes;
  assign fail_count = fails;

  // only the regions that have a slave behind them
  function automatic chip_sel_t region_of(input bus_addr_t a, input logic m);
    if (!m && a <= 32'h0000_3fff)
      return cs_ram;
    if (m && a >= 32'hffff_8000 && a <= 32'hffff_bfff)
      return cs_ram;
    if (a >= 32'h0080_0800 && a <= 32'h0080_0fff)
      return cs_io;
    return cs_none;
  endfunction

  function automatic bus_data_t merge_bytes(input bus_data_t old, input bus_data_t wd,
                                            input bus_be_t be);
    bus_data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b])
        res[8*b +: 8] = wd[8*b +: 8];
    end
    return res;
  endfunction

  function automatic bus_data_t expect_read(input bus_addr_t a, input logic m);
    case (region_of(a, m))
      cs_ram:  return ram_model[a[31:2] % `BUS_RAM_WORDS];
      cs_io:   return io_model[a[31:2] % `BUS_IO_REGS];
      default: return '0; // unmapped or no slave
    endcase
  endfunction

  task automatic check_access(input string who, input bus_addr_t a, input logic wr,
                              input bus_be_t be, input bus_data_t wd, input bus_data_t rd);
    bus_data_t exp;
    exp = expect_read(a, map);
    if (!wr && rd !== exp) begin
      fails++;
      $display("Error %s: %s read at %h expected %h actual %h",
               test_name, who, a, exp, rd);
    end else if (!wr) begin
      passes++;
    end else if (region_of(a, map) == cs_ram) begin
      ram_model[a[31:2] % `BUS_RAM_WORDS] = merge_bytes(exp, wd, be);
    end else if (region_of(a, map) == cs_io) begin
      io_model[a[31:2] % `BUS_IO_REGS] = merge_bytes(exp, wd, be);
    end
  endtask

  // request high with wait low marks the data-visible cycle
  always @(negedge clock) begin
    if (!reset_n) begin
      for (int i = 0; i < `BUS_IO_REGS; i++) begin
        io_model[i] = '0;
      end
    end else begin
      if ((cpu_read || cpu_write) && !cpu_wait)
        check_access("cpu", cpu_address, cpu_write, cpu_be, cpu_writedata, cpu_readdata);
      if (vga_read && !vga_wait)
        check_access("vga", vga_address, 1'b0, 4'hf, '0, vga_readdata);
    end
  end

endmodule

/* bench/tb_bus.sv */
`timescale 1ns/1ps
`include "bus_cfg.svh"

module tb_bus
  import bus_pkg::*;
;

  localparam int cycle_ns       = 8;
  localparam int total_accesses = 2 * `BUS_RAM_WORDS + 220; // fill, readback, other tests

  logic        clock = 1'b0;
  logic        reset_n;
  bus_addr_t   cpu_address, vga_address;
  logic        cpu_read, cpu_write, vga_read, map;
  bus_be_t     cpu_be;
  bus_data_t   cpu_writedata, cpu_readdata, vga_readdata;
  logic        cpu_wait, vga_wait;
  int          pass_count, fail_count;
  int          order_errors = 0;
  int          fails_at_start;
  logic [31:0] rng;
  time         cpu_done_at, vga_done_at;

  bus_top u_dut (.*);
  bus_checker u_check (.*);

  always #(cycle_ns / 2) clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic bus_data_t fill_word(input bus_addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c; // every address bit counts
  endfunction

  task automatic cpu_access(input bus_addr_t a, input logic wr, input bus_be_t be,
                            input bus_data_t wd, input logic m);
    @(posedge clock);
    #1;
    map           = m;
    cpu_address   = a;
    cpu_be        = be;
    cpu_writedata = wd;
    cpu_read      = ~wr;
    cpu_write     = wr;
    do begin
      @(negedge clock);
    end while (cpu_wait);
    cpu_done_at = $time;
    @(posedge clock);
    #1;
    cpu_read  = 1'b0;
    cpu_write = 1'b0;
  endtask

  task automatic vga_access(input bus_addr_t a, input logic m);
    @(posedge clock);
    #1;
    map         = m;
    vga_address = a;
    vga_read    = 1'b1;
    do begin
      @(negedge clock);
    end while (vga_wait);
    vga_done_at = $time;
    @(posedge clock);
    #1;
    vga_read = 1'b0;
  endtask

  task automatic start_test(input string name);
    u_check.test_name = name;
    fails_at_start    = fail_count + order_errors;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d errors", u_check.test_name,
             fail_count + order_errors - fails_at_start);
  endtask

  initial begin
    #(total_accesses * 20 * cycle_ns + 1000);
    $display("watchdog expired, an access never completed and the bus hung");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    bus_addr_t   a;
    reset_n       = 1'b0;
    cpu_address   = '0;
    cpu_read      = 1'b0;
    cpu_write     = 1'b0;
    cpu_be        = '0;
    cpu_writedata = '0;
    vga_address   = '0;
    vga_read      = 1'b0;
    map           = 1'b0;
    rng           = 32'he4b5_6594;
    repeat (2) @(posedge clock);
    #1;
    reset_n = 1'b1;

    start_test("ram_write_read");
    for (int i = 0; i < `BUS_RAM_WORDS; i++)
      cpu_access(bus_addr_t'(4 * i), 1'b1, 4'hf, fill_word(bus_addr_t'(4 * i)), 1'b0);
    for (int i = 0; i < `BUS_RAM_WORDS; i++)
      cpu_access(bus_addr_t'(4 * i), 1'b0, 4'hf, '0, 1'b0);
    end_test();

    start_test("io_byte_enables");
    for (int k = 0; k < 4; k++)
      cpu_access(32'h0080_0800 + 4 * k, 1'b1, 4'hf, 32'h1111_1111 * (k + 1), 1'b0);
    cpu_access(32'h0080_0800, 1'b1, 4'b0001, 32'haaaa_aaaa, 1'b0);
    cpu_access(32'h0080_0804, 1'b1, 4'b0110, 32'hbbbb_bbbb, 1'b0);
    cpu_access(32'h0080_0808, 1'b1, 4'b1000, 32'hcccc_cccc, 1'b1);
    cpu_access(32'h0080_080c, 1'b1, 4'b0101, 32'hdddd_dddd, 1'b0);
    for (int k = 0; k < 4; k++)
      cpu_access(32'h0080_0800 + 4 * k, 1'b0, 4'hf, '0, 1'b0);
    end_test();

    start_test("map_alias");
    cpu_access(32'h0000_0010, 1'b1, 4'hf, 32'h5eed_0010, 1'b0);
    cpu_access(32'hffff_8010, 1'b0, 4'hf, '0, 1'b1);
    cpu_access(32'h0000_0010, 1'b0, 4'hf, '0, 1'b1); // slave-less ssram window under map high
    end_test();

    start_test("arbitration");
    cpu_access(32'h0000_0040, 1'b1, 4'hf, 32'hfeed_0040, 1'b0);
    fork
      cpu_access(32'h0000_0044, 1'b0, 4'hf, '0, 1'b0);
      vga_access(32'h0000_0040, 1'b0);
    join
    if (cpu_done_at >= vga_done_at) begin
      $display("arbitration: the VGA read finished before the CPU read it competed with");
      order_errors++;
    end
    end_test();

    start_test("unmapped_reads");
    cpu_access(32'h0040_0000, 1'b0, 4'hf, '0, 1'b0);
    cpu_access(32'hffff_0000, 1'b0, 4'hf, '0, 1'b0); // boot rom left out
    end_test();

    start_test("random_mix");
    for (int n = 0; n < 200; n++) begin
      rng = xorshift(rng);
      r   = rng;
      rng = xorshift(rng); // write data
      if (r[2])
        a = 32'h0080_0800 + {r[16:8], 2'b00};
      else if (r[1])
        a = 32'hffff_8000 + {r[17:8], 2'b00};
      else
        a = {20'h0, r[17:8], 2'b00};
      if (r[0])
        vga_access(a, r[1]);
      else
        cpu_access(a, r[3], r[7:4], rng, r[1]);
    end
    end_test();

    $display("%0d reads matched, %0d failures", pass_count, fail_count + order_errors);
    if (fail_count + order_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* include/bus_cfg.svh */
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// internal RAM depth in 32-bit words
`define BUS_RAM_WORDS 256

// number of IO registers in the bank
`define BUS_IO_REGS 4

// cycles spent in the access state
`define BUS_ACCESS_CYCLES 1

`endif

/* verilog/bus_controller.sv */
`timescale 1ns/1ps
`include "bus_cfg.svh"

module bus_controller
  import bus_pkg::*, map_pkg::*;
(
  input  logic      clock,
  input  logic      reset_n,
  input  bus_addr_t cpu_address,
  input  logic      cpu_read,
  input  logic      cpu_write,
  input  bus_be_t   cpu_be,
  input  bus_data_t cpu_writedata,
  input  bus_addr_t vga_address,
  input  logic      vga_read,
  input  logic      map,
  output bus_data_t cpu_readdata,
  output bus_data_t vga_readdata,
  output logic      cpu_wait,
  output logic      vga_wait,
  sys_bus_if.ctrl   bus
);

  localparam int master_cpu = 0;
  localparam int master_vga = 1;

  bus_state_t state, state_next;
  bus_delay_t delay, delay_next;
  logic [1:0] grant, grant_next;
  bus_addr_t  addr;
  chip_sel_t  cs;
  bus_data_t  slave_rdata;
  logic       cpu_req;
  logic       req_gone;

  assign cpu_req  = cpu_read | cpu_write;
  assign req_gone = (grant[master_cpu] & ~cpu_req) | (grant[master_vga] & ~vga_read);

  // granted master drives the bus
  assign addr = grant[master_cpu] ? cpu_address :
                grant[master_vga] ? vga_address : '0;

  assign bus.address    = addr;
  assign bus.read       = (grant[master_cpu] & cpu_read) | (grant[master_vga] & vga_read);
  assign bus.write      = grant[master_cpu] & cpu_write & (state == st_access);
  assign bus.be         = grant[master_cpu] ? cpu_be :
                          grant[master_vga] ? 4'b1111 : 4'b0000; // vga reads full words
  assign bus.writedata  = grant[master_cpu] ? cpu_writedata : '0;
  assign bus.chipselect = (state != st_idle) ? cs : cs_none;
  assign bus.start      = (state == st_start);

  assign cpu_wait = grant[master_cpu] ? (state != st_done) : 1'b1;
  assign vga_wait = grant[master_vga] ? (state != st_done) : 1'b1;

  // unmapped and slave-less regions read as zero
  always_comb begin
    case (bus.chipselect)
      cs_ram:  slave_rdata = bus.ram_readdata;
      cs_io:   slave_rdata = bus.io_readdata;
      default: slave_rdata = '0;
    endcase
  end

  assign cpu_readdata = grant[master_cpu] ? slave_rdata : '0;
  assign vga_readdata = grant[master_vga] ? slave_rdata : '0;

  always_comb begin
    if (!map) begin
      if (addr <= 32'h0000_3fff)
        cs = cs_ram;
      else if (addr >= 32'h0000_4000 && addr <= 32'h000f_ffff)
        cs = cs_ssram;
      else if (addr >= 32'h0080_0000 && addr <= 32'h0080_07ff)
        cs = cs_led;
      else if (addr >= 32'h0080_0800 && addr <= 32'h0080_0fff)
        cs = cs_io;
      else if (addr >= 32'hffff_0000 && addr <= 32'hffff_ffbf)
        cs = cs_rom;
      else if (addr >= 32'hffff_ffc0)
        cs = cs_vectors;
      else
        cs = cs_none;
    end else begin
      if (addr <= 32'h000f_ffff)
        cs = cs_ssram; // ssram moves to zero
      else if (addr >= 32'h0080_0000 && addr <= 32'h0080_07ff)
        cs = cs_led;
      else if (addr >= 32'h0080_0800 && addr <= 32'h0080_0fff)
        cs = cs_io;
      else if (addr >= 32'hffff_8000 && addr <= 32'hffff_bfff)
        cs = cs_ram; // must win over the rom window
      else if (addr >= 32'hffff_0000 && addr <= 32'hffff_ffbf)
        cs = cs_rom;
      else if (addr >= 32'hffff_ffc0)
        cs = cs_vectors;
      else
        cs = cs_none;
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= st_idle;
      delay <= '0;
      grant <= '0;
    end else begin
      state <= state_next;
      delay <= delay_next;
      grant <= grant_next;
    end
  end

  always_comb begin
    state_next = state;
    delay_next = delay;
    grant_next = grant;
    case (state)
      st_idle: begin
        if (cpu_req) begin // cpu has priority
          state_next = st_start;
          grant_next = 2'b01;
        end else if (vga_read) begin
          state_next = st_start;
          grant_next = 2'b10;
        end
      end
      st_start: begin
        delay_next = bus_delay_t'(`BUS_ACCESS_CYCLES);
        if (req_gone) begin
          grant_next = '0;
          state_next = st_idle;
        end else begin
          state_next = st_access;
        end
      end
      st_access: begin
        if (req_gone) begin // master gave up
          grant_next = '0;
          state_next = st_idle;
        end else if (delay <= bus_delay_t'(1)) begin
          state_next = st_done;
        end else begin
          delay_next = delay - bus_delay_t'(1);
        end
      end
      st_done: begin
        if (req_gone) begin
          grant_next = '0;
          state_next = st_idle;
        end
      end
      default: state_next = st_idle;
    endcase
  end

endmodule

/* verilog/bus_pkg.sv */
`include "bus_cfg.svh"

package bus_pkg;

  typedef logic [31:0] bus_addr_t; // byte address
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_be_t;   // one bit per byte lane

  // word index into the internal RAM
  typedef logic [$clog2(`BUS_RAM_WORDS)-1:0] bus_ram_idx_t;

  // IO register select
  typedef logic [$clog2(`BUS_IO_REGS)-1:0] bus_io_idx_t;

  // access state delay counter up to BUS_ACCESS_CYCLES
  typedef logic [$clog2(`BUS_ACCESS_CYCLES+1)-1:0] bus_delay_t;

  typedef enum logic [1:0] {
    st_idle   = 2'b00,
    st_start  = 2'b01, // address phase
    st_access = 2'b10, // write strobe here
    st_done   = 2'b11  // data visible
  } bus_state_t;

endpackage

/* verilog/bus_top.sv */
`timescale 1ns/1ps

module bus_top
  import bus_pkg::*;
(
  input  logic      clock,
  input  logic      reset_n,
  input  bus_addr_t cpu_address,
  input  logic      cpu_read,
  input  logic      cpu_write,
  input  bus_be_t   cpu_be,
  input  bus_data_t cpu_writedata,
  input  bus_addr_t vga_address,
  input  logic      vga_read,
  input  logic      map,
  output bus_data_t cpu_readdata,
  output bus_data_t vga_readdata,
  output logic      cpu_wait,
  output logic      vga_wait
);

  sys_bus_if bus ();

  bus_controller u_ctrl (
    .clock         (clock),
    .reset_n       (reset_n),
    .cpu_address   (cpu_address),
    .cpu_read      (cpu_read),
    .cpu_write     (cpu_write),
    .cpu_be        (cpu_be),
    .cpu_writedata (cpu_writedata),
    .vga_address   (vga_address),
    .vga_read      (vga_read),
    .map           (map),
    .cpu_readdata  (cpu_readdata),
    .vga_readdata  (vga_readdata),
    .cpu_wait      (cpu_wait),
    .vga_wait      (vga_wait),
    .bus           (bus.ctrl)
  );

  word_ram u_ram (
    .clock (clock),
    .bus   (bus.ram)
  );

  io_regs u_io (
    .clock   (clock),
    .reset_n (reset_n),
    .bus     (bus.io)
  );

endmodule

/* verilog/io_regs.sv */
`timescale 1ns/1ps
`include "bus_cfg.svh"

module io_regs
  import bus_pkg::*, map_pkg::*;
(
  input logic   clock,
  input logic   reset_n,
  sys_bus_if.io bus
);

  bus_data_t   regs [`BUS_IO_REGS];
  bus_io_idx_t idx_q;
  logic        sel;

  assign sel = (bus.chipselect == cs_io);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      idx_q <= '0;
      for (int i = 0; i < `BUS_IO_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (sel && bus.start)
        idx_q <= bus_io_idx_t'(bus.address[31:2] % `BUS_IO_REGS); // latch in address phase
      if (sel && bus.write) begin
        for (int b = 0; b < 4; b++) begin
          if (bus.be[b])
            regs[idx_q][8*b +: 8] <= bus.writedata[8*b +: 8];
        end
      end
    end
  end

  // readback from the index latched in start
  always_ff @(posedge clock) begin
    if (sel && bus.read)
      bus.io_readdata <= regs[idx_q];
  end

endmodule

/* verilog/map_pkg.sv */
package map_pkg;

  typedef logic [3:0] chip_sel_t;

  localparam chip_sel_t cs_none    = 4'h0; // unmapped
  localparam chip_sel_t cs_vectors = 4'h1; // interrupt vectors
  localparam chip_sel_t cs_rom     = 4'h2; // boot ROM
  localparam chip_sel_t cs_ram     = 4'h3; // internal word RAM
  localparam chip_sel_t cs_io      = 4'h4; // IO register bank
  localparam chip_sel_t cs_led     = 4'h5; // LED matrix
  localparam chip_sel_t cs_ssram   = 4'h6; // external SSRAM

endpackage

/* verilog/sys_bus_if.sv */
`timescale 1ns/1ps

interface sys_bus_if
  import bus_pkg::*, map_pkg::*;
;

  bus_addr_t address;
  logic      read;
  logic      write;
  bus_be_t   be;
  bus_data_t writedata;
  chip_sel_t chipselect;
  logic      start;

  bus_data_t ram_readdata;
  bus_data_t io_readdata;

  modport ctrl (
    output address, read, write, be, writedata, chipselect, start,
    input  ram_readdata, io_readdata
  );

  modport ram (
    input  address, read, write, be, writedata, chipselect, start,
    output ram_readdata
  );

  modport io (
    input  address, read, write, be, writedata, chipselect, start,
    output io_readdata
  );

endinterface

/* verilog/word_ram.sv */
`timescale 1ns/1ps
`include "bus_cfg.svh"

module word_ram
  import bus_pkg::*, map_pkg::*;
(
  input logic    clock,
  sys_bus_if.ram bus
);

  bus_data_t    mem [`BUS_RAM_WORDS];
  bus_ram_idx_t idx;
  logic         sel;

  assign sel = (bus.chipselect == cs_ram);

  // word address wraps on the depth
  assign idx = bus_ram_idx_t'(bus.address[31:2] % `BUS_RAM_WORDS);

  always_ff @(posedge clock) begin
    if (sel && bus.write) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.be[b])
          mem[idx][8*b +: 8] <= bus.writedata[8*b +: 8];
      end
    end
  end

  // ready by the done state
  always_ff @(posedge clock) begin
    if (sel && bus.read)
      bus.ram_readdata <= mem[idx];
  end

endmodule
